// File: design/move_order_macros.svh
`ifndef MOVE_ORDER_MACROS_SVH
`define MOVE_ORDER_MACROS_SVH

// sorter capacity and the number of move slots per depth in the stack
`define MO_MAX_MOVES 32

// depth slots held in the move stack
`define MO_MAX_DEPTH 8

// the sort key has the same width as the signed evaluation
`define MO_EVAL_BITS 16

// move encoding fields
`define MO_SQ_BITS 6
`define MO_PROMO_BITS 4

`endif

// File: design/chess_pkg.sv
`include "move_order_macros.svh"

package chess_pkg;

    typedef logic [`MO_SQ_BITS-1:0] square_t;

    // from and to squares plus the promotion piece or zero for none
    typedef struct packed {
        square_t                   from_sq;
        square_t                   to_sq;
        logic [`MO_PROMO_BITS-1:0] promo;
    } move_t;

    typedef logic signed [`MO_EVAL_BITS-1:0] eval_t;

    typedef logic [$clog2(`MO_MAX_DEPTH)-1:0] depth_t;

    typedef logic [$clog2(`MO_MAX_MOVES)-1:0] move_idx_t;

    // one bit wider than an index so a full batch can be counted
    typedef logic [$clog2(`MO_MAX_MOVES+1)-1:0] move_count_t;

endpackage

// File: design/order_pkg.sv
`include "move_order_macros.svh"

package order_pkg;

    import chess_pkg::*;

    // unsigned compare of this key orders the same as signed compare of the eval
    typedef logic [`MO_EVAL_BITS-1:0] sort_key_t;

    typedef struct packed {
        move_t  move;
        eval_t  eval;
        depth_t depth;
        logic   last;
    } cand_t;

    typedef struct packed {
        move_t     move;
        sort_key_t key;
    } sort_entry_t;

    typedef struct packed {
        depth_t      depth;
        move_count_t count;
        move_t       best_move;
        eval_t       best_eval;
    } batch_done_t;

    // depth in the upper bits, so the struct doubles as the stack address
    typedef struct packed {
        depth_t    depth;
        move_idx_t idx;
    } fetch_req_t;

    typedef struct packed {
        move_t move;
    } fetch_rsp_t;

    typedef enum logic {
        SORT_FILL,
        SORT_DRAIN
    } sorter_state_t;

    function automatic sort_key_t eval_to_key(eval_t eval);
        return {~eval[`MO_EVAL_BITS-1], eval[`MO_EVAL_BITS-2:0]};
    endfunction

    function automatic eval_t key_to_eval(sort_key_t key);
        return eval_t'({~key[`MO_EVAL_BITS-1], key[`MO_EVAL_BITS-2:0]});
    endfunction

endpackage

// File: design/cand_intake.sv
`timescale 1ns/1ps

module cand_intake (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  order_pkg::cand_t      cand_in,
    input  logic                  cand_valid_in,
    input  logic                  ins_ready,
    output logic                  cand_ready_out,
    output order_pkg::sort_entry_t ins_entry,
    output chess_pkg::depth_t     ins_depth,
    output logic                  ins_last,
    output logic                  ins_valid
);
    import order_pkg::*;

    logic take;

    // the register can take a new candidate when empty or when its entry leaves
    assign cand_ready_out = !ins_valid || ins_ready;
    assign take = cand_valid_in && cand_ready_out;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ins_valid <= 1'b0;
        end else if (cand_ready_out) begin
            ins_valid <= cand_valid_in;
        end
    end

    // key is encoded here so the sorter compares plain unsigned values
    always_ff @(posedge clk_in) begin
        if (take) begin
            ins_entry.move <= cand_in.move;
            ins_entry.key  <= eval_to_key(cand_in.eval);
            ins_depth      <= cand_in.depth;
            ins_last       <= cand_in.last;
        end
    end

endmodule

// File: design/insertion_sorter.sv
`timescale 1ns/1ps
`include "move_order_macros.svh"

module insertion_sorter #(
    parameter int MAX_LEN = `MO_MAX_MOVES
) (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  order_pkg::sort_entry_t ins_entry,
    input  chess_pkg::depth_t      ins_depth,
    input  logic                   ins_last,
    input  logic                   ins_valid,
    output logic                   ins_ready,
    output logic                   wr_valid,
    output order_pkg::fetch_req_t  wr_addr,
    output chess_pkg::move_t       wr_move,
    output order_pkg::batch_done_t done_out,
    output logic                   done_valid_out
);
    import chess_pkg::*;
    import order_pkg::*;

    sorter_state_t state;
    sort_entry_t   arr      [MAX_LEN];
    sort_entry_t   next_arr [MAX_LEN];
    logic          key_ge   [MAX_LEN];
    move_count_t   count;
    move_count_t   next_count;
    move_idx_t     wr_idx;
    depth_t        batch_depth;
    logic          accept;

    assign ins_ready = (state == SORT_FILL);
    assign accept    = ins_valid && ins_ready;

    // the array is kept sorted, so the slots with key_ge set form a prefix
    always_comb begin
        for (int i = 0; i < MAX_LEN; i++) begin
            key_ge[i] = (move_count_t'(i) < count) && (arr[i].key >= ins_entry.key);
        end
    end

    // the newcomer lands right after the last entry that ranks at least as high
    always_comb begin
        next_arr[0] = key_ge[0] ? arr[0] : ins_entry;
        for (int i = 1; i < MAX_LEN; i++) begin
            if (key_ge[i]) begin
                next_arr[i] = arr[i];
            end else if (key_ge[i-1]) begin
                next_arr[i] = ins_entry;
            end else begin
                next_arr[i] = arr[i-1];
            end
        end
    end

    // when full, the entry pushed off the tail is simply lost
    assign next_count = (count == move_count_t'(MAX_LEN)) ? count : count + 1'b1;

    assign wr_valid     = (state == SORT_DRAIN) && (count != '0);
    assign wr_addr.depth = batch_depth;
    assign wr_addr.idx   = wr_idx;
    assign wr_move       = arr[0].move;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state          <= SORT_FILL;
            count          <= '0;
            wr_idx         <= '0;
            done_valid_out <= 1'b0;
        end else begin
            done_valid_out <= 1'b0;
            case (state)
                SORT_FILL: begin
                    if (accept) begin
                        count <= next_count;
                        if (ins_last) begin
                            state  <= SORT_DRAIN;
                            wr_idx <= '0;
                        end
                    end
                end
                SORT_DRAIN: begin
                    wr_idx <= wr_idx + 1'b1;
                    if (count <= move_count_t'(1)) begin
                        state          <= SORT_FILL;
                        count          <= '0;
                        done_valid_out <= 1'b1;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: begin
                    state <= SORT_FILL;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            arr         <= next_arr;
            batch_depth <= ins_depth;
            // summary is taken from the array as it will stand when draining starts
            if (ins_last) begin
                done_out.depth     <= ins_depth;
                done_out.count     <= next_count;
                done_out.best_move <= next_arr[0].move;
                done_out.best_eval <= key_to_eval(next_arr[0].key);
            end
        end else if (state == SORT_DRAIN) begin
            for (int i = 0; i < MAX_LEN - 1; i++) begin
                arr[i] <= arr[i+1];
            end
        end
    end

endmodule

// File: design/move_stack_ram.sv
`timescale 1ns/1ps
`include "move_order_macros.svh"

module move_stack_ram (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  wr_valid,
    input  order_pkg::fetch_req_t wr_addr,
    input  chess_pkg::move_t      wr_move,
    input  order_pkg::fetch_req_t fetch_in,
    input  logic                  fetch_valid_in,
    output order_pkg::fetch_rsp_t fetch_out,
    output logic                  fetch_valid_out
);
    import chess_pkg::*;

    localparam int DEPTH = `MO_MAX_DEPTH * `MO_MAX_MOVES;

    move_t      mem [DEPTH];
    move_t      rd_q;
    logic [1:0] valid_pipe;

    // depth and index concatenated form the word address
    always_ff @(posedge clk_in) begin
        if (wr_valid) begin
            mem[wr_addr] <= wr_move;
        end
    end

    // nonblocking read beside the write gives read-first behavior
    always_ff @(posedge clk_in) begin
        if (fetch_valid_in) begin
            rd_q <= mem[fetch_in];
        end
        if (valid_pipe[0]) begin
            fetch_out.move <= rd_q;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid_pipe <= 2'b00;
        end else begin
            valid_pipe <= {valid_pipe[0], fetch_valid_in};
        end
    end

    assign fetch_valid_out = valid_pipe[1];

endmodule

// File: design/move_order_top.sv
`timescale 1ns/1ps

module move_order_top (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  order_pkg::cand_t       cand_in,
    input  logic                   cand_valid_in,
    output logic                   cand_ready_out,
    output order_pkg::batch_done_t done_out,
    output logic                   done_valid_out,
    input  order_pkg::fetch_req_t  fetch_in,
    input  logic                   fetch_valid_in,
    output order_pkg::fetch_rsp_t  fetch_out,
    output logic                   fetch_valid_out
);
    import chess_pkg::*;
    import order_pkg::*;

    sort_entry_t ins_entry;
    depth_t      ins_depth;
    logic        ins_last;
    logic        ins_valid;
    logic        ins_ready;

    logic        wr_valid;
    fetch_req_t  wr_addr;
    move_t       wr_move;

    cand_intake u_intake (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .cand_in        (cand_in),
        .cand_valid_in  (cand_valid_in),
        .ins_ready      (ins_ready),
        .cand_ready_out (cand_ready_out),
        .ins_entry      (ins_entry),
        .ins_depth      (ins_depth),
        .ins_last       (ins_last),
        .ins_valid      (ins_valid)
    );

    insertion_sorter u_sorter (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .ins_entry      (ins_entry),
        .ins_depth      (ins_depth),
        .ins_last       (ins_last),
        .ins_valid      (ins_valid),
        .ins_ready      (ins_ready),
        .wr_valid       (wr_valid),
        .wr_addr        (wr_addr),
        .wr_move        (wr_move),
        .done_out       (done_out),
        .done_valid_out (done_valid_out)
    );

    move_stack_ram u_stack (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .wr_valid        (wr_valid),
        .wr_addr         (wr_addr),
        .wr_move         (wr_move),
        .fetch_in        (fetch_in),
        .fetch_valid_in  (fetch_valid_in),
        .fetch_out       (fetch_out),
        .fetch_valid_out (fetch_valid_out)
    );

endmodule

// File: bench/move_order_properties.sv
`timescale 1ns/1ps

module move_order_properties (
    input logic             clk_in,
    input logic             rst_in,
    input order_pkg::cand_t cand_in,
    input logic             cand_valid_in,
    input logic             cand_ready_out,
    input logic             done_valid_out,
    input logic             fetch_valid_in,
    input logic             fetch_valid_out
);

    int assert_fails = 0;

    a_fetch_latency: assert property (@(posedge clk_in) disable iff (rst_in)
        fetch_valid_out == $past(fetch_valid_in, 2))
        else begin
            $error("fetch response not two cycles after its request");
            assert_fails++;
        end

    a_done_single: assert property (@(posedge clk_in) disable iff (rst_in)
        done_valid_out |=> !done_valid_out)
        else begin
            $error("done pulse held longer than one cycle");
            assert_fails++;
        end

    // an offered candidate waits unchanged while intake is full
    a_cand_stable: assert property (@(posedge clk_in) disable iff (rst_in)
        (cand_valid_in && !cand_ready_out) |=> $stable(cand_in))
        else begin
            $error("candidate changed while stalled");
            assert_fails++;
        end

    a_ready_after_reset: assert property (@(posedge clk_in)
        $fell(rst_in) |-> cand_ready_out)
        else begin
            $error("intake not ready after reset");
            assert_fails++;
        end

endmodule

bind move_order_top move_order_properties u_props (
    .clk_in          (clk_in),
    .rst_in          (rst_in),
    .cand_in         (cand_in),
    .cand_valid_in   (cand_valid_in),
    .cand_ready_out  (cand_ready_out),
    .done_valid_out  (done_valid_out),
    .fetch_valid_in  (fetch_valid_in),
    .fetch_valid_out (fetch_valid_out)
);

// File: bench/move_order_checker.sv
`timescale 1ns/1ps
`include "move_order_macros.svh"

module move_order_checker (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  order_pkg::batch_done_t done_out,
    input  logic                   done_valid_out,
    input  order_pkg::fetch_req_t  fetch_in,
    input  logic                   fetch_valid_in,
    input  order_pkg::fetch_rsp_t  fetch_out,
    input  logic                   fetch_valid_out,
    output int                     error_count,
    output int                     check_count,
    output int                     pending
);
    import chess_pkg::*;
    import order_pkg::*;

    typedef struct packed {
        fetch_req_t addr;
        move_t      move;
    } exp_fetch_t;

    typedef struct packed {
        fetch_req_t  req;
        logic [31:0] cyc;
    } req_rec_t;

    batch_done_t exp_done_q [$];
    exp_fetch_t  exp_fetch_q [$];
    req_rec_t    req_q [$];
    int          cyc;

    initial begin
        int          fd;
        string       line;
        string       tag;
        int          a, b, f, t, p, r;
        batch_done_t d;
        exp_fetch_t  e;
        error_count = 0;
        check_count = 0;
        cyc = 0;
        fd = $fopen("bench/move_order_testdata.txt", "r");
        if (fd == 0) begin
            $display("checker could not open the test data file");
            error_count = 1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.substr(0, 0) == "D") begin
                    void'($sscanf(line, "%s %d %d %d %d %d %d", tag, a, b, f, t, p, r));
                    d.depth          = depth_t'(a);
                    d.count          = move_count_t'(b);
                    d.best_move.from_sq = square_t'(f);
                    d.best_move.to_sq   = square_t'(t);
                    d.best_move.promo   = p[`MO_PROMO_BITS-1:0];
                    d.best_eval      = eval_t'(r);
                    exp_done_q.push_back(d);
                end else if (line.len() > 0 && line.substr(0, 0) == "E") begin
                    void'($sscanf(line, "%s %d %d %d %d %d %d", tag, a, b, f, t, p, r));
                    for (int k = 0; k < r; k++) begin
                        e.addr.depth     = depth_t'(a);
                        e.addr.idx       = move_idx_t'(b + k);
                        e.move.from_sq   = square_t'(f + k);
                        e.move.to_sq     = square_t'(t + k);
                        e.move.promo     = p[`MO_PROMO_BITS-1:0];
                        exp_fetch_q.push_back(e);
                    end
                end
            end
            $fclose(fd);
        end
        pending = exp_done_q.size() + exp_fetch_q.size();
    end

    always @(posedge clk_in) begin
        batch_done_t d;
        exp_fetch_t  e;
        req_rec_t    q;
        cyc = cyc + 1;
        if (!rst_in) begin
            if (fetch_valid_in) begin
                req_q.push_back('{req: fetch_in, cyc: cyc});
            end
            if (done_valid_out) begin
                check_count++;
                if (exp_done_q.size() == 0) begin
                    $display("unexpected batch summary at %0t", $time);
                    error_count++;
                end else begin
                    d = exp_done_q.pop_front();
                    if (done_out !== d) begin
                        $display("** Error %0t: summary depth %0d count %0d move %h eval %0d",
                                 $time, done_out.depth, done_out.count, done_out.best_move,
                                 done_out.best_eval,
                                 ", expected depth %0d count %0d move %h eval %0d",
                                 d.depth, d.count, d.best_move, d.best_eval);
                        error_count++;
                    end
                end
            end
            if (fetch_valid_out) begin
                check_count++;
                if (req_q.size() == 0 || exp_fetch_q.size() == 0) begin
                    $display("fetch response with no request or no expected move at %0t",
                             $time);
                    error_count++;
                end else begin
                    q = req_q.pop_front();
                    e = exp_fetch_q.pop_front();
                    if (cyc - q.cyc != 2) begin
                        $display("** Error %0t: fetch latency %0d cycles, expected 2",
                                 $time, cyc - q.cyc);
                        error_count++;
                    end
                    if (q.req !== e.addr || fetch_out.move !== e.move) begin
                        $display("** Error %0t: fetch d%0d i%0d move %h",
                                 $time, q.req.depth, q.req.idx, fetch_out.move,
                                 ", expected d%0d i%0d move %h",
                                 e.addr.depth, e.addr.idx, e.move);
                        error_count++;
                    end
                end
            end
        end
        pending = exp_done_q.size() + exp_fetch_q.size() + req_q.size();
    end

endmodule

// File: bench/move_order_tb.sv
`timescale 1ns/1ps
`include "move_order_macros.svh"

module move_order_tb;
    import chess_pkg::*;
    import order_pkg::*;

    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        logic        reread;
        depth_t      depth;
        move_count_t count;
    } fetch_plan_t;

    logic        clk_in;
    logic        rst_in;
    cand_t       cand_in;
    logic        cand_valid_in;
    logic        cand_ready_out;
    batch_done_t done_out;
    logic        done_valid_out;
    fetch_req_t  fetch_in;
    logic        fetch_valid_in;
    fetch_rsp_t  fetch_out;
    logic        fetch_valid_out;

    int          error_count;
    int          check_count;
    int          pending;
    int          timeouts;
    int          done_seen;
    logic [31:0] rng_state;
    cand_t       cand_q [$];
    fetch_plan_t plan_q [$];

    move_order_top u_move_order_top (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .cand_in         (cand_in),
        .cand_valid_in   (cand_valid_in),
        .cand_ready_out  (cand_ready_out),
        .done_out        (done_out),
        .done_valid_out  (done_valid_out),
        .fetch_in        (fetch_in),
        .fetch_valid_in  (fetch_valid_in),
        .fetch_out       (fetch_out),
        .fetch_valid_out (fetch_valid_out)
    );

    move_order_checker u_checker (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .done_out        (done_out),
        .done_valid_out  (done_valid_out),
        .fetch_in        (fetch_in),
        .fetch_valid_in  (fetch_valid_in),
        .fetch_out       (fetch_out),
        .fetch_valid_out (fetch_valid_out),
        .error_count     (error_count),
        .check_count     (check_count),
        .pending         (pending)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        if (!rst_in && done_valid_out) begin
            done_seen <= done_seen + 1;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic load_stimulus();
        int          fd;
        string       line;
        string       tag;
        int          f, t, p, ev, dp, last, rep, step;
        cand_t       c;
        fetch_plan_t pl;
        fd = $fopen("bench/move_order_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            timeouts++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.substr(0, 0) == "C") begin
                void'($sscanf(line, "%s %d %d %d %d %d %d %d %d",
                              tag, f, t, p, ev, dp, last, rep, step));
                for (int k = 0; k < rep; k++) begin
                    c.move.from_sq = square_t'(f + k);
                    c.move.to_sq   = square_t'(t + k);
                    c.move.promo   = p[`MO_PROMO_BITS-1:0];
                    c.eval         = eval_t'(ev + k * step);
                    c.depth        = depth_t'(dp);
                    c.last         = (last != 0) && (k == rep - 1);
                    cand_q.push_back(c);
                end
            end else if (line.len() > 0 && (line.substr(0, 0) == "D" ||
                                            line.substr(0, 0) == "R")) begin
                void'($sscanf(line, "%s %d %d", tag, dp, f));
                pl.reread = (tag == "R");
                pl.depth  = depth_t'(dp);
                pl.count  = move_count_t'(f);
                plan_q.push_back(pl);
            end
        end
        $fclose(fd);
    endtask

    // called 5 ns after an edge and returns 5 ns after the accepting edge
    task automatic send_cand(input cand_t c);
        int   waited;
        logic rdy;
        waited = 0;
        rdy = 1'b0;
        cand_in = c;
        cand_valid_in = 1'b1;
        while (!rdy && waited < WAIT_LIMIT) begin
            #90;
            rdy = cand_ready_out;
            @(posedge clk_in);
            #5;
            waited++;
        end
        if (!rdy) begin
            $display("timed out at %0t waiting for intake ready", $time);
            timeouts++;
        end
        cand_valid_in = 1'b0;
    endtask

    task automatic send_all_cands();
        int gap;
        foreach (cand_q[i]) begin
            rng_state = xorshift(rng_state);
            gap = rng_state % 3;
            repeat (gap) begin
                @(posedge clk_in);
                #5;
            end
            send_cand(cand_q[i]);
        end
    endtask

    task automatic fetch_depth(input depth_t d, input move_count_t n);
        for (int i = 0; i < n; i++) begin
            fetch_in.depth = d;
            fetch_in.idx   = move_idx_t'(i);
            fetch_valid_in = 1'b1;
            @(posedge clk_in);
            #5;
        end
        fetch_valid_in = 1'b0;
    endtask

    task automatic fetch_all_batches();
        int batches;
        int waited;
        batches = 0;
        foreach (plan_q[i]) begin
            if (!plan_q[i].reread) begin
                batches++;
                waited = 0;
                while (done_seen < batches && waited < WAIT_LIMIT) begin
                    @(posedge clk_in);
                    #5;
                    waited++;
                end
                if (done_seen < batches) begin
                    $display("timed out at %0t waiting for batch %0d to finish", $time, batches);
                    timeouts++;
                end
            end
            fetch_depth(plan_q[i].depth, plan_q[i].count);
        end
    endtask

    initial begin
        int waited;
        rst_in         = 1'b1;
        cand_in        = '0;
        cand_valid_in  = 1'b0;
        fetch_in       = '0;
        fetch_valid_in = 1'b0;
        timeouts       = 0;
        done_seen      = 0;
        rng_state      = 32'd76;
        load_stimulus();
        repeat (2) @(posedge clk_in);
        #5;
        rst_in = 1'b0;
        fork
            send_all_cands();
            fetch_all_batches();
        join
        waited = 0;
        while (pending != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk_in);
            #5;
            waited++;
        end
        if (pending != 0) begin
            $display("timed out with %0d expected results still outstanding", pending);
            timeouts++;
        end
        $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
                 check_count, error_count, u_move_order_top.u_props.assert_fails, timeouts);
        if (error_count == 0 && timeouts == 0 && check_count > 0 &&
            u_move_order_top.u_props.assert_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: bench/move_order_testdata.txt
# C from to promo eval depth last rep eval_step   (candidates, rep copies with from/to +1)
# D depth count best_from best_to best_promo best_eval   (expected summary, in done order)
# E depth idx from to promo rep   (expected moves read back, rep entries with idx/from/to +1)
# R depth count   (read a depth again after all batches)
# batch at depth 1 with distinct scores of both signs
C 12 28 0 35 1 0 1 0
C 6 21 0 -120 1 0 1 0
C 1 18 0 250 1 0 1 0
C 11 27 0 -5 1 0 1 0
C 52 36 0 32767 1 0 1 0
C 57 42 0 -32768 1 1 1 0
D 1 6 52 36 0 32767
E 1 0 52 36 0 1
E 1 1 1 18 0 1
E 1 2 12 28 0 1
E 1 3 11 27 0 1
E 1 4 6 21 0 1
E 1 5 57 42 0 1
# batch at depth 3 with equal scores, kept in arrival order
C 8 16 0 40 3 0 3 0
C 48 56 1 40 3 0 1 0
C 49 57 2 40 3 1 1 0
D 3 5 8 16 0 40
E 3 0 8 16 0 3
E 3 3 48 56 1 1
E 3 4 49 57 2 1
# 35 candidates at depth 5, ties at -40 straddle the capacity boundary
C 0 20 0 50 5 0 30 -3
C 30 50 0 -40 5 0 4 0
C 34 54 0 60 5 1 1 0
D 5 32 34 54 0 60
E 5 0 34 54 0 1
E 5 1 0 20 0 30
E 5 31 30 50 0 1
# depth 2 batch arrives while depth 5 drains
C 20 30 0 7 2 0 1 0
C 21 31 0 -7 2 0 1 0
C 22 32 0 7 2 0 1 0
C 23 33 3 100 2 1 1 0
D 2 4 23 33 3 100
E 2 0 23 33 3 1
E 2 1 20 30 0 1
E 2 2 22 32 0 1
E 2 3 21 31 0 1
# depth 1 must still hold its first batch
R 1 6
E 1 0 52 36 0 1
E 1 1 1 18 0 1
E 1 2 12 28 0 1
E 1 3 11 27 0 1
E 1 4 6 21 0 1
E 1 5 57 42 0 1

// File: verilog.f
+incdir+design
design/chess_pkg.sv
design/order_pkg.sv
design/cand_intake.sv
design/insertion_sorter.sv
design/move_stack_ram.sv
design/move_order_top.sv
bench/move_order_properties.sv
bench/move_order_checker.sv
bench/move_order_tb.sv
